//--- build.f
+incdir+verilog
verilog/axil_pkg.sv
verilog/hello_regs_pkg.sv
verilog/axil_write_ctrl.sv
verilog/axil_read_ctrl.sv
verilog/hello_world_regs.sv
verilog/hello_world_top.sv
verification/tb_clock_gen.sv
verification/hello_world_checker.sv
verification/hello_world_properties.sv
verification/hello_world_tb.sv

//--- verification/hello_world_tb.sv
/*
 * Hello-world register slave testbench
 * Walks a table of bus writes, bus reads and DIP changes, hands each
 * expectation to the checker and prints a closing summary
 */

`timescale 1ns/1ps

`include "hello_world_macros.svh"

module hello_world_tb
  import axil_pkg::*;
  import hello_regs_pkg::*;
();

  localparam logic [1:0] OP_IDLE  = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_READ  = 2'd2;
  localparam logic [1:0] OP_VDIP  = 2'd3;
  localparam int N_ROWS      = 13;
  localparam int WAIT_LIMIT  = 20;
  localparam int SETTLE_LIMIT = 10;

  // Handshake flags the wait loop can watch
  localparam int F_RESET   = 0;
  localparam int F_AWREADY = 1;
  localparam int F_WREADY  = 2;
  localparam int F_BVALID  = 3;
  localparam int F_ARREADY = 4;
  localparam int F_RVALID  = 5;

  typedef struct packed {
    logic [1:0] op;
    axil_addr_t addr;
    axil_data_t data;
    axil_data_t exp_data;
    axil_resp_t exp_resp;
    logic [3:0] hold;
  } row_t;

  logic       clk_main_a0;
  logic       rst_main_n_sync;
  logic       awvalid;
  axil_addr_t awaddr;
  logic       awready;
  logic       wvalid;
  axil_data_t wdata;
  axil_strb_t wstrb;
  logic       wready;
  logic       bvalid;
  axil_resp_t bresp;
  logic       bready;
  logic       arvalid;
  axil_addr_t araddr;
  logic       arready;
  logic       rvalid;
  axil_data_t rdata;
  axil_resp_t rresp;
  logic       rready;
  vled_t      vdip;
  vled_t      vled;

  row_t  stim_tab [N_ROWS];
  bit    timed_out = 1'b0;
  string op_name [4] = '{"idle", "write", "read", "vdip"};
  string flag_name [6] = '{"reset release", "awready", "wready", "bvalid",
                           "arready", "rvalid"};

  tb_clock_gen i_clock_gen (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync)
  );

  hello_world_top i_dut (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid (awvalid), .awaddr (awaddr), .awready (awready),
    .wvalid  (wvalid),  .wdata  (wdata),  .wstrb   (wstrb),  .wready (wready),
    .bvalid  (bvalid),  .bresp  (bresp),  .bready  (bready),
    .arvalid (arvalid), .araddr (araddr), .arready (arready),
    .rvalid  (rvalid),  .rdata  (rdata),  .rresp   (rresp),  .rready (rready),
    .vdip    (vdip),    .vled   (vled)
  );

  hello_world_checker i_checker (
    .awready (awready),
    .wready  (wready),
    .arready (arready),
    .rvalid  (rvalid),
    .rdata   (rdata),
    .rresp   (rresp),
    .bvalid  (bvalid),
    .bresp   (bresp),
    .vled    (vled)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------
  // Expected readback has byte 0 in the top lane
  function automatic axil_data_t byte_reverse(input axil_data_t w);
    axil_data_t r;
    for (int i = 0; i < 4; i++)
      r[8*i +: 8] = w[8*(3-i) +: 8];
    return r;
  endfunction

  function automatic logic flag_value(input int which);
    case (which)
      F_RESET:   return rst_main_n_sync;
      F_AWREADY: return awready;
      F_WREADY:  return wready;
      F_BVALID:  return bvalid;
      F_ARREADY: return arready;
      default:   return rvalid;
    endcase
  endfunction

  // Polls once per cycle and gives up after WAIT_LIMIT cycles
  task automatic wait_until_high(input int which);
    int n;
    n = 0;
    while (flag_value(which) !== 1'b1 && n < WAIT_LIMIT)
    begin
      @(posedge clk_main_a0);
      #1;
      n++;
    end
    if (flag_value(which) !== 1'b1)
    begin
      $display("Timeout: %s did not arrive within %0d cycles", flag_name[which], WAIT_LIMIT);
      timed_out = 1'b1;
    end
  endtask

  task automatic set_row(input int idx, input logic [1:0] op, input axil_addr_t addr,
                         input axil_data_t data, input axil_data_t exp_data,
                         input axil_resp_t exp_resp, input logic [3:0] hold);
    stim_tab[idx] = '{op, addr, data, exp_data, exp_resp, hold};
  endtask

  // ----------------------------------------------------------------------
  // Bus operations entered and left 1 ns after a rising edge
  // ----------------------------------------------------------------------
  task automatic bus_write(input axil_addr_t addr, input axil_data_t data,
                           input axil_resp_t exp_resp);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = 4'hf;
    wait_until_high(F_AWREADY);
    @(posedge clk_main_a0);
    #1;
    awvalid = 1'b0;
    wait_until_high(F_WREADY);
    @(posedge clk_main_a0);
    #1;
    wvalid = 1'b0;
    wait_until_high(F_BVALID);
    i_checker.expect_write_resp(exp_resp);
    bready = 1'b1;
    @(posedge clk_main_a0);
    #1;
    bready = 1'b0;
  endtask

  // Beat checked on each of the hold cycles with rready low
  task automatic bus_read(input axil_addr_t addr, input axil_data_t exp_data,
                          input axil_resp_t exp_resp, input int hold);
    int k;
    arvalid = 1'b1;
    araddr  = addr;
    wait_until_high(F_ARREADY);
    @(posedge clk_main_a0);
    #1;
    arvalid = 1'b0;
    wait_until_high(F_RVALID);
    for (k = 0; k < hold; k++)
    begin
      i_checker.expect_read(exp_data, exp_resp);
      @(posedge clk_main_a0);
      #1;
    end
    i_checker.expect_read(exp_data, exp_resp);
    rready = 1'b1;
    @(posedge clk_main_a0);
    #1;
    rready = 1'b0;
  endtask

  // Apply the DIP value and poll vled through the sync and mask latency
  task automatic apply_vdip(input vled_t value, input vled_t exp_vled);
    int n;
    vdip = value;
    n = 0;
    while (vled !== exp_vled && n < SETTLE_LIMIT)
    begin
      @(posedge clk_main_a0);
      #1;
      n++;
    end
    i_checker.expect_vled(exp_vled);
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial
  begin
    axil_data_t w1;
    axil_data_t w2;
    axil_data_t w3;
    vled_t      d1;
    int         i;
    int         errors_before;
    void'($urandom(32'h15b5));
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    rready  = 1'b0;
    vdip    = '0;

    w1 = $urandom;
    w2 = $urandom;
    w3 = $urandom;
    d1 = $urandom;
    set_row(0, OP_IDLE, '0, '0, '0, AXIL_RESP_OKAY, 0);
    set_row(1, OP_READ, `HELLO_WORLD_REG_ADDR, '0, '0, AXIL_RESP_OKAY, 0);
    set_row(2, OP_WRITE, `HELLO_WORLD_REG_ADDR, w1, '0, AXIL_RESP_OKAY, 0);
    set_row(3, OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_reverse(w1), AXIL_RESP_OKAY, 0);
    set_row(4, OP_READ, `VLED_REG_ADDR, '0, {16'h0, w1[15:0]}, AXIL_RESP_OKAY, 0);
    set_row(5, OP_VDIP, '0, {16'h0, d1}, {16'h0, w1[15:0] & d1}, AXIL_RESP_OKAY, 0);
    set_row(6, OP_WRITE, `HELLO_WORLD_REG_ADDR, w2, '0, AXIL_RESP_OKAY, 0);
    set_row(7, OP_VDIP, '0, 32'h0000_ffff, {16'h0, w2[15:0]}, AXIL_RESP_OKAY, 0);
    set_row(8, OP_READ, 32'h0000_0508, '0, '0, AXIL_RESP_SLVERR, 0);
    set_row(9, OP_WRITE, 32'h0000_0600, w3, '0, AXIL_RESP_OKAY, 0);
    set_row(10, OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_reverse(w2), AXIL_RESP_OKAY, 0);
    set_row(11, OP_READ, `HELLO_WORLD_REG_ADDR, '0, byte_reverse(w2), AXIL_RESP_OKAY, 5);
    set_row(12, OP_READ, `VLED_REG_ADDR, '0, {16'h0, w2[15:0]}, AXIL_RESP_OKAY, 3);

    wait_until_high(F_RESET);
    @(posedge clk_main_a0);
    #1;

    for (i = 0; i < N_ROWS && !timed_out; i++)
    begin
      errors_before = i_checker.error_count;
      case (stim_tab[i].op)
        OP_IDLE:  i_checker.expect_idle();
        OP_WRITE: bus_write(stim_tab[i].addr, stim_tab[i].data, stim_tab[i].exp_resp);
        OP_READ:  bus_read(stim_tab[i].addr, stim_tab[i].exp_data, stim_tab[i].exp_resp,
                           stim_tab[i].hold);
        default:  apply_vdip(stim_tab[i].data[15:0], stim_tab[i].exp_data[15:0]);
      endcase
      $display("Row %0d %s addr %h: %0d errors", i, op_name[stim_tab[i].op],
               stim_tab[i].addr, i_checker.error_count - errors_before);
      @(posedge clk_main_a0);
      #1;
    end

    $display("%0d of %0d rows run, %0d errors, %0d timeouts", i, N_ROWS,
             i_checker.error_count, timed_out);
    if (i_checker.error_count == 0 && !timed_out)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

//--- verification/hello_world_properties.sv
/*
 * AXI4-Lite handshake assertions
 * Bound into both bus controllers. Each binding ties the signals of
 * the other controller to an idle bus.
 */

`timescale 1ns/1ps

module hello_world_properties
  import axil_pkg::*;
(
  input logic       clk_main_a0,
  input logic       rst_main_n_sync,
  input logic       bvalid,
  input logic       bready,
  input logic       rvalid,
  input logic       rready,
  input logic       arvalid,
  input logic       arready,
  input axil_data_t rdata
);

  // Write response stays up until taken
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read beat stays up and unchanged until taken
  a_rvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else $error("rvalid or rdata changed before rready");

  // No new read address from acceptance up to the read beat
  a_arready_block: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (arvalid && arready) |=> !arready ##1 (rvalid && !arready))
    else $error("arready rose or rvalid was late after a read address");

endmodule

// Write controller with the read signals tied to an idle bus
bind axil_write_ctrl hello_world_properties i_write_props (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .bvalid          (bvalid),
  .bready          (bready),
  .rvalid          (1'b0),
  .rready          (1'b1),
  .arvalid         (1'b0),
  .arready         (1'b0),
  .rdata           (32'h0)
);

// Read controller with the write signals tied to an idle bus
bind axil_read_ctrl hello_world_properties i_read_props (
  .clk_main_a0     (clk_main_a0),
  .rst_main_n_sync (rst_main_n_sync),
  .bvalid          (1'b0),
  .bready          (1'b1),
  .rvalid          (rvalid),
  .rready          (rready),
  .arvalid         (arvalid),
  .arready         (arready),
  .rdata           (rdata)
);

//--- verification/hello_world_checker.sv
/*
 * Hello-world slave checker
 * Samples the DUT outputs when asked, compares them with the expected
 * values handed over by the testbench and counts mismatches
 */

`timescale 1ns/1ps

module hello_world_checker
  import axil_pkg::*;
  import hello_regs_pkg::*;
(
  input logic       awready,
  input logic       wready,
  input logic       arready,
  input logic       rvalid,
  input axil_data_t rdata,
  input axil_resp_t rresp,
  input logic       bvalid,
  input axil_resp_t bresp,
  input vled_t      vled
);

  // Mismatches seen so far
  int error_count = 0;

  // Compares one value and logs a mismatch
  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      error_count++;
    end
  endtask

  // ----------------------------------------------------------------------
  // Per-channel checks
  // ----------------------------------------------------------------------
  // Read beat is only meaningful while rvalid is up
  task automatic expect_read(input axil_data_t exp_data, input axil_resp_t exp_resp);
    compare("rvalid", rvalid, 1'b1);
    compare("rdata", rdata, exp_data);
    compare("rresp", rresp, exp_resp);
  endtask

  task automatic expect_write_resp(input axil_resp_t exp_resp);
    compare("bvalid", bvalid, 1'b1);
    compare("bresp", bresp, exp_resp);
  endtask

  task automatic expect_vled(input vled_t exp_vled);
    compare("vled", vled, exp_vled);
  endtask

  // Idle handshakes and dark LEDs straight out of reset
  task automatic expect_idle();
    compare("vled", vled, '0);
    compare("bvalid", bvalid, 1'b0);
    compare("rvalid", rvalid, 1'b0);
    compare("awready", awready, 1'b1);
    compare("wready", wready, 1'b0);
    compare("arready", arready, 1'b1);
  endtask

endmodule

//--- verification/tb_clock_gen.sv
/*
 * Testbench clock and reset
 * 100 ns clock, reset held low for the first 8 cycles
 */

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_main_a0,
  output logic rst_main_n_sync
);

  initial
  begin
    clk_main_a0 = 1'b0;
    forever #50 clk_main_a0 = ~clk_main_a0;
  end

  // Release just after an edge, like the rest of the stimulus
  initial
  begin
    rst_main_n_sync = 1'b0;
    repeat (8) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
  end

endmodule

//--- verilog/hello_world_top.sv
/*
 * Hello-world AXI4-Lite register slave
 * Top level of the custom-logic example. Ties the write control, the
 * read control and the register block together. Single-beat accesses
 * only, one write and one read in flight at a time.
 */

`timescale 1ns/1ps

module hello_world_top
  import axil_pkg::*;
  import hello_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,

  // Write address channel
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  output logic       awready,

  // Write data channel
  // Strobes are accepted but not used, every write is a full word
  input  logic       wvalid,
  input  axil_data_t wdata,
  input  axil_strb_t wstrb,
  output logic       wready,

  // Write response channel
  output logic       bvalid,
  output axil_resp_t bresp,
  input  logic       bready,

  // Read address channel
  input  logic       arvalid,
  input  axil_addr_t araddr,
  output logic       arready,

  // Read data channel
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp,
  input  logic       rready,

  // Virtual DIP switches in, masked virtual LEDs out
  input  vled_t      vdip,
  output vled_t      vled
);

  // ----------------------------------------------------------------------
  // Internal wires
  // ----------------------------------------------------------------------
  // Address latched at write-address acceptance
  axil_addr_t wr_addr;

  // Register values presented to the read mux
  axil_data_t hello_swapped;
  vled_t      vled_word;

  // Write handshake and response
  axil_write_ctrl i_write_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .wvalid          (wvalid),
    .bready          (bready),
    .awready         (awready),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .wr_addr         (wr_addr)
  );

  // Read handshake, decode and data mux
  axil_read_ctrl i_read_ctrl (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .rready          (rready),
    .hello_swapped   (hello_swapped),
    .vled_word       (vled_word),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp)
  );

  // wready doubles as the register write strobe
  hello_world_regs i_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_en           (wready),
    .wr_addr         (wr_addr),
    .wdata           (wdata),
    .vdip            (vdip),
    .hello_swapped   (hello_swapped),
    .vled_word       (vled_word),
    .vled            (vled)
  );

endmodule

//--- verilog/hello_world_regs.sv
/*
 * Hello-world register block
 * Holds the hello-world word and returns it byte-reversed, shadows its
 * low half into the virtual LED word and drives the LED outputs masked
 * by the synchronized virtual DIP switches.
 */

`timescale 1ns/1ps

`include "hello_world_macros.svh"

module hello_world_regs
  import axil_pkg::*;
  import hello_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       wr_en,
  input  axil_addr_t wr_addr,
  input  axil_data_t wdata,
  input  vled_t      vdip,
  output axil_data_t hello_swapped,
  output vled_t      vled_word,
  output vled_t      vled
);

  hello_word_t hello_q;

  // DIP synchronizer chain, index 0 sees the raw input
  vled_t       vdip_sync [`VDIP_SYNC_STAGES];

  // ----------------------------------------------------------------------
  // Hello-world register
  // ----------------------------------------------------------------------
  // Full-word writes only, other addresses leave it alone
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      hello_q.word <= '0;
    else if (wr_en && (wr_addr == `HELLO_WORLD_REG_ADDR))
      hello_q.word <= wdata;
  end

  // Readback with byte 0 in the top lane
  assign hello_swapped = {hello_q.bytes[0], hello_q.bytes[1],
                          hello_q.bytes[2], hello_q.bytes[3]};

  // ----------------------------------------------------------------------
  // Virtual LED shadow
  // ----------------------------------------------------------------------
  // Read-only copy of the low half, one cycle behind
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      vled_word <= '0;
    else
      vled_word <= hello_q.word[`VLED_W-1:0];
  end

  // ----------------------------------------------------------------------
  // DIP synchronizer and LED output
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      for (int i = 0; i < `VDIP_SYNC_STAGES; i++)
        vdip_sync[i] <= '0;
    end
    else
    begin
      vdip_sync[0] <= vdip;
      for (int i = 1; i < `VDIP_SYNC_STAGES; i++)
        vdip_sync[i] <= vdip_sync[i-1];
    end
  end

  // Switch off any LED whose DIP is low, registered for a clean output
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      vled <= '0;
    else
      vled <= vled_word & vdip_sync[`VDIP_SYNC_STAGES-1];
  end

endmodule

//--- verilog/axil_read_ctrl.sv
/*
 * AXI4-Lite read control
 * Registers the read address on acceptance, decodes it against the
 * two register addresses and returns data and response one cycle
 * later. Anything else reads as zero with SLVERR.
 */

`timescale 1ns/1ps

`include "hello_world_macros.svh"

module axil_read_ctrl
  import axil_pkg::*;
  import hello_regs_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       arvalid,
  input  axil_addr_t araddr,
  input  logic       rready,
  input  axil_data_t hello_swapped,
  input  vled_t      vled_word,
  output logic       arready,
  output logic       rvalid,
  output axil_data_t rdata,
  output axil_resp_t rresp
);

  // Address accepted, data not yet returned
  logic       ar_pending;
  axil_addr_t araddr_q;

  // Decode results and the selected beat
  logic       hit_hello;
  logic       hit_vled;
  axil_data_t rdata_next;
  axil_resp_t rresp_next;

  // ----------------------------------------------------------------------
  // Read address
  // ----------------------------------------------------------------------
  // Blocked while a read is pending or its data is still waiting
  assign arready = !ar_pending && !rvalid;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      ar_pending <= 1'b0;
    else if (arvalid && arready)
      ar_pending <= 1'b1;
    else
      ar_pending <= 1'b0;
  end

  // Capture only on a real handshake
  always_ff @(posedge clk_main_a0)
  begin
    if (arvalid && arready)
      araddr_q <= araddr;
  end

  // ----------------------------------------------------------------------
  // Decode and data select
  // ----------------------------------------------------------------------
  assign hit_hello = (araddr_q == `HELLO_WORLD_REG_ADDR);
  assign hit_vled  = (araddr_q == `VLED_REG_ADDR);

  always_comb
  begin
    rdata_next = '0;
    rresp_next = AXIL_RESP_OKAY;
    if (hit_hello)
      rdata_next = hello_swapped;
    else if (hit_vled)
      // LED word zero-extended to the bus width
      rdata_next = {{(`AXIL_DATA_W-`VLED_W){1'b0}}, vled_word};
    else
      rresp_next = AXIL_RESP_SLVERR;
  end

  // ----------------------------------------------------------------------
  // Read response
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      rvalid <= 1'b0;
    else if (ar_pending)
      rvalid <= 1'b1;
    else if (rvalid && rready)
      rvalid <= 1'b0;
  end

  // Beat loaded once per read and held under back-pressure
  always_ff @(posedge clk_main_a0)
  begin
    if (ar_pending)
    begin
      rdata <= rdata_next;
      rresp <= rresp_next;
    end
  end

endmodule

//--- verilog/axil_write_ctrl.sv
/*
 * AXI4-Lite write control
 * Accepts one write address at a time, latches it, passes wvalid
 * through as wready while the write is active and returns an OKAY
 * response. Address decode is left to the register block.
 */

`timescale 1ns/1ps

module axil_write_ctrl
  import axil_pkg::*;
(
  input  logic       clk_main_a0,
  input  logic       rst_main_n_sync,
  input  logic       awvalid,
  input  axil_addr_t awaddr,
  input  logic       wvalid,
  input  logic       bready,
  output logic       awready,
  output logic       wready,
  output logic       bvalid,
  output axil_resp_t bresp,
  output axil_addr_t wr_addr
);

  // Set on address acceptance, cleared when the response is taken
  logic wr_active;

  // ----------------------------------------------------------------------
  // Write address
  // ----------------------------------------------------------------------
  // Free for a new address whenever no write is active
  assign awready = ~wr_active;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      wr_active <= 1'b0;
    else if (wr_active && bvalid && bready)
      wr_active <= 1'b0;
    else if (awvalid && awready)
      wr_active <= 1'b1;
  end

  // Address held for the whole write
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
      wr_addr <= awaddr;
  end

  // ----------------------------------------------------------------------
  // Write data and response
  // ----------------------------------------------------------------------
  // Data is taken in the same cycle it is offered
  assign wready = wr_active && wvalid;

  // Response raised after the first data beat, held until bready
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      bvalid <= 1'b0;
    else if (bvalid && bready)
      bvalid <= 1'b0;
    else if (wready)
      bvalid <= 1'b1;
  end

  // Unmapped writes are dropped silently, so never an error
  assign bresp = AXIL_RESP_OKAY;

endmodule

//--- verilog/hello_regs_pkg.sv
/*
 * Hello-world register types
 * The hello-world word seen as a whole or as bytes, and the LED word
 */

package hello_regs_pkg;

  `include "hello_world_macros.svh"

  // ----------------------------------------------------------------------
  // Register views
  // ----------------------------------------------------------------------
  // Same 32 bits, two decodes
  // word  is used for bus writes and for the LED shadow
  // bytes is used to build the byte-reversed readback
  // bytes[0] is bits 7:0
  typedef union packed {
    logic [`AXIL_DATA_W-1:0]       word;
    logic [`AXIL_DATA_W/8-1:0][7:0] bytes;
  } hello_word_t;

  // Virtual LED or DIP word
  // Same width for the LED shadow, the DIP inputs and the masked output
  typedef logic [`VLED_W-1:0] vled_t;

endpackage

//--- verilog/axil_pkg.sv
/*
 * AXI4-Lite bus types
 * Address, data, strobe and response types shared by the bus-facing
 * blocks, plus the two response codes this slave returns
 */

package axil_pkg;

  `include "hello_world_macros.svh"

  // ----------------------------------------------------------------------
  // Bus fields
  // ----------------------------------------------------------------------
  // Byte address, full 32-bit space
  typedef logic [31:0] axil_addr_t;

  // One data beat
  typedef logic [`AXIL_DATA_W-1:0] axil_data_t;

  // One strobe bit per data byte
  typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;

  // BRESP / RRESP encoding
  typedef logic [1:0] axil_resp_t;

  // Only OKAY and SLVERR are ever returned
  localparam axil_resp_t AXIL_RESP_OKAY   = 2'b00;
  localparam axil_resp_t AXIL_RESP_SLVERR = 2'b10;

endpackage

//--- verilog/hello_world_macros.svh
/*
 * Hello-world register slave constants
 * Register map, bus data width, LED width and DIP synchronizer depth
 */

`ifndef HELLO_WORLD_MACROS_SVH
`define HELLO_WORLD_MACROS_SVH

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
// Byte addresses of the two 32-bit registers
`define HELLO_WORLD_REG_ADDR 32'h0000_0500
`define VLED_REG_ADDR        32'h0000_0504

// ----------------------------------------------------------------------
// Widths and depths
// ----------------------------------------------------------------------
`define AXIL_DATA_W 32
`define VLED_W      16

// Two flops on the asynchronous DIP inputs
`define VDIP_SYNC_STAGES 2

`endif
